//--- flist.f
sh_axi_pkg.sv
sh_host_pkg.sv
sh_fifo.sv
sh_pcis_dispatch.sv
sh_pcis_cpl.sv
sh_pcis_host.sv
tb_cl_mem.sv
tb_sh_pcis_host.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      -f flist.f --top-module tb_sh_pcis_host; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_sh_pcis_host)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
   exit 0
fi
exit 1

//--- sh_axi_pkg.sv
`default_nettype none

package sh_axi_pkg;

   // ------------------------------
   // bus widths
   // ------------------------------
   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int STRB_W = 8;
   localparam int ID_W   = 6;

   typedef logic [ADDR_W-1:0] axi_addr_t;
   typedef logic [DATA_W-1:0] axi_data_t;
   typedef logic [STRB_W-1:0] axi_strb_t;
   typedef logic [ID_W-1:0]   axi_id_t;
   typedef logic [1:0]        axi_resp_t;

   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

   // ------------------------------
   // channel payloads
   // ------------------------------
   // shared by AW and AR, single beat only
   typedef struct packed {
      axi_addr_t addr;
      axi_id_t   id;
   } axi_ax_t;

   typedef struct packed {
      axi_data_t data;
      axi_strb_t strb;
      logic      last;
   } axi_w_t;

   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } axi_b_t;

   typedef struct packed {
      axi_id_t   id;
      axi_data_t data;
      axi_resp_t resp;
      logic      last;
   } axi_r_t;

endpackage

`default_nettype wire

//--- sh_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sh_fifo #(
   parameter int DEPTH = 4,
   parameter int WIDTH = 8
) (
   input  logic             clk_out,
   input  logic             sync_rst_n,
   input  logic             push_i,
   input  logic [WIDTH-1:0] din_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] dout_o,
   output logic             full_o,
   output logic             empty_o
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // pointers wrap at DEPTH, not only at a power of two
   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_out) begin
      if (push_i) begin
         mem[wr_ptr] <= din_i;
      end
   end

   assign dout_o  = mem[rd_ptr];
   assign full_o  = (count == CNT_W'(DEPTH));
   assign empty_o = (count == '0);

   assert property (@(posedge clk_out) disable iff (!sync_rst_n) full_o |-> !push_i);
   assert property (@(posedge clk_out) disable iff (!sync_rst_n) empty_o |-> !pop_i);

endmodule

`default_nettype wire

//--- sh_host_pkg.sv
`default_nettype none

package sh_host_pkg;

   localparam int WORD_W    = 32;
   localparam int REQ_DEPTH = 4;
   localparam int CPL_DEPTH = 16;

   typedef logic [WORD_W-1:0] word_t;

   typedef enum logic {
      REQ_WRITE,
      REQ_READ
   } req_kind_t;

   // poke or peek from the host side
   typedef struct packed {
      req_kind_t             kind;
      sh_axi_pkg::axi_addr_t addr;
      word_t                 wdata;
      sh_axi_pkg::axi_id_t   id;
   } host_req_t;

   // rdata is the whole beat, zero for writes
   typedef struct packed {
      req_kind_t             kind;
      sh_axi_pkg::axi_id_t   id;
      sh_axi_pkg::axi_resp_t resp;
      sh_axi_pkg::axi_data_t rdata;
   } host_cpl_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WRITE,
      ST_READ
   } disp_state_t;

endpackage

`default_nettype wire

//--- sh_pcis_cpl.sv
`timescale 1ns/1ps
`default_nettype none

module sh_pcis_cpl (
   input  logic                   clk_out,
   input  logic                   sync_rst_n,
   input  logic                   bvalid_i,
   output logic                   bready_o,
   input  sh_axi_pkg::axi_b_t     b_i,
   input  logic                   rvalid_i,
   output logic                   rready_o,
   input  sh_axi_pkg::axi_r_t     r_i,
   input  logic                   cpl_full_i,
   output logic                   cpl_push_o,
   output sh_host_pkg::host_cpl_t cpl_o
);

   logic b_hs;
   logic r_hs;

   // B wins over R, both stall on a full queue
   assign bready_o = !cpl_full_i;
   assign rready_o = !cpl_full_i && !bvalid_i;

   assign b_hs = bvalid_i && bready_o;
   assign r_hs = rvalid_i && rready_o;

   assign cpl_push_o = b_hs || r_hs;

   always_comb begin
      if (b_hs) begin
         cpl_o.kind  = sh_host_pkg::REQ_WRITE;
         cpl_o.id    = b_i.id;
         cpl_o.resp  = b_i.resp;
         cpl_o.rdata = '0;
      end else begin
         cpl_o.kind  = sh_host_pkg::REQ_READ;
         cpl_o.id    = r_i.id;
         cpl_o.resp  = r_i.resp;
         cpl_o.rdata = r_i.data;
      end
   end

   // ------------------------------
   // checks
   // ------------------------------
   // a stalled R beat stays on the bus until taken
   assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      rvalid_i && !rready_o |=> rvalid_i && $stable(r_i));

   // requests are single beat, so every R beat closes its burst
   assert property (@(posedge clk_out) disable iff (!sync_rst_n) r_hs |-> r_i.last);

endmodule

`default_nettype wire

//--- sh_pcis_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module sh_pcis_dispatch (
   input  logic                   clk_out,
   input  logic                   sync_rst_n,
   input  sh_host_pkg::host_req_t req_head_i,
   input  logic                   req_empty_i,
   output logic                   req_pop_o,
   output logic                   awvalid_o,
   input  logic                   awready_i,
   output sh_axi_pkg::axi_ax_t    aw_o,
   output logic                   wvalid_o,
   input  logic                   wready_i,
   output sh_axi_pkg::axi_w_t     w_o,
   output logic                   arvalid_o,
   input  logic                   arready_i,
   output sh_axi_pkg::axi_ax_t    ar_o
);

   sh_host_pkg::disp_state_t state;
   sh_axi_pkg::axi_ax_t      ax_next;
   sh_axi_pkg::axi_w_t       w_next;
   logic                     aw_done;
   logic                     w_done;

   assign req_pop_o = (state == sh_host_pkg::ST_IDLE) && !req_empty_i;

   // a channel is done once its valid is gone or handshakes now
   assign aw_done = !awvalid_o || awready_i;
   assign w_done  = !wvalid_o || wready_i;

   // ------------------------------
   // lane steering
   // ------------------------------
   always_comb begin
      logic lane;
      lane         = req_head_i.addr[2];
      ax_next.addr = req_head_i.addr;
      ax_next.id   = req_head_i.id;
      w_next.data  = '0;
      w_next.data[sh_host_pkg::WORD_W*lane +: sh_host_pkg::WORD_W] = req_head_i.wdata;
      w_next.strb  = '0;
      w_next.strb[(sh_host_pkg::WORD_W/8)*lane +: sh_host_pkg::WORD_W/8] = '1;
      w_next.last  = 1'b1;
   end

   // ------------------------------
   // FSM and valids
   // ------------------------------
   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state     <= sh_host_pkg::ST_IDLE;
         awvalid_o <= 1'b0;
         wvalid_o  <= 1'b0;
         arvalid_o <= 1'b0;
      end else begin
         case (state)
            sh_host_pkg::ST_IDLE: begin
               if (req_pop_o && req_head_i.kind == sh_host_pkg::REQ_WRITE) begin
                  state     <= sh_host_pkg::ST_WRITE;
                  awvalid_o <= 1'b1;
                  wvalid_o  <= 1'b1;
               end else if (req_pop_o) begin
                  state     <= sh_host_pkg::ST_READ;
                  arvalid_o <= 1'b1;
               end
            end
            sh_host_pkg::ST_WRITE: begin
               // AW and W may finish in either order
               if (awvalid_o && awready_i) begin
                  awvalid_o <= 1'b0;
               end
               if (wvalid_o && wready_i) begin
                  wvalid_o <= 1'b0;
               end
               if (aw_done && w_done) begin
                  state <= sh_host_pkg::ST_IDLE;
               end
            end
            sh_host_pkg::ST_READ: begin
               if (arready_i) begin
                  arvalid_o <= 1'b0;
                  state     <= sh_host_pkg::ST_IDLE;
               end
            end
            default: state <= sh_host_pkg::ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_out) begin
      if (req_pop_o && req_head_i.kind == sh_host_pkg::REQ_WRITE) begin
         aw_o <= ax_next;
         w_o  <= w_next;
      end
      if (req_pop_o && req_head_i.kind == sh_host_pkg::REQ_READ) begin
         ar_o <= ax_next;
      end
   end

   // held until ready
   assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o));
   assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      wvalid_o && !wready_i |=> wvalid_o && $stable(w_o));
   assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o));

endmodule

`default_nettype wire

//--- sh_pcis_host.sv
`timescale 1ns/1ps
`default_nettype none

module sh_pcis_host (
   input  logic                   clk_out,
   input  logic                   sync_rst_n,
   input  logic                   req_valid_i,
   output logic                   req_ready_o,
   input  sh_host_pkg::host_req_t req_i,
   output logic                   cpl_valid_o,
   input  logic                   cpl_ready_i,
   output sh_host_pkg::host_cpl_t cpl_o,
   output logic                   awvalid_o,
   input  logic                   awready_i,
   output sh_axi_pkg::axi_ax_t    aw_o,
   output logic                   wvalid_o,
   input  logic                   wready_i,
   output sh_axi_pkg::axi_w_t     w_o,
   input  logic                   bvalid_i,
   output logic                   bready_o,
   input  sh_axi_pkg::axi_b_t     b_i,
   output logic                   arvalid_o,
   input  logic                   arready_i,
   output sh_axi_pkg::axi_ax_t    ar_o,
   input  logic                   rvalid_i,
   output logic                   rready_o,
   input  sh_axi_pkg::axi_r_t     r_i
);

   sh_host_pkg::host_req_t req_head;
   sh_host_pkg::host_cpl_t cpl_new;
   logic                   req_full;
   logic                   req_empty;
   logic                   req_pop;
   logic                   cpl_full;
   logic                   cpl_empty;
   logic                   cpl_push;

   assign req_ready_o = !req_full;
   assign cpl_valid_o = !cpl_empty;

   // ------------------------------
   // request path
   // ------------------------------
   sh_fifo #(
      .DEPTH (sh_host_pkg::REQ_DEPTH),
      .WIDTH ($bits(sh_host_pkg::host_req_t))
   ) req_q (
      .clk_out    (clk_out),
      .sync_rst_n (sync_rst_n),
      .push_i     (req_valid_i && req_ready_o),
      .din_i      (req_i),
      .pop_i      (req_pop),
      .dout_o     (req_head),
      .full_o     (req_full),
      .empty_o    (req_empty)
   );

   sh_pcis_dispatch sh_pcis_dispatch_i (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .req_head_i  (req_head),
      .req_empty_i (req_empty),
      .req_pop_o   (req_pop),
      .awvalid_o   (awvalid_o),
      .awready_i   (awready_i),
      .aw_o        (aw_o),
      .wvalid_o    (wvalid_o),
      .wready_i    (wready_i),
      .w_o         (w_o),
      .arvalid_o   (arvalid_o),
      .arready_i   (arready_i),
      .ar_o        (ar_o)
   );

   // ------------------------------
   // completion path
   // ------------------------------
   sh_pcis_cpl sh_pcis_cpl_i (
      .clk_out    (clk_out),
      .sync_rst_n (sync_rst_n),
      .bvalid_i   (bvalid_i),
      .bready_o   (bready_o),
      .b_i        (b_i),
      .rvalid_i   (rvalid_i),
      .rready_o   (rready_o),
      .r_i        (r_i),
      .cpl_full_i (cpl_full),
      .cpl_push_o (cpl_push),
      .cpl_o      (cpl_new)
   );

   sh_fifo #(
      .DEPTH (sh_host_pkg::CPL_DEPTH),
      .WIDTH ($bits(sh_host_pkg::host_cpl_t))
   ) cpl_q (
      .clk_out    (clk_out),
      .sync_rst_n (sync_rst_n),
      .push_i     (cpl_push),
      .din_i      (cpl_new),
      .pop_i      (cpl_valid_o && cpl_ready_i),
      .dout_o     (cpl_o),
      .full_o     (cpl_full),
      .empty_o    (cpl_empty)
   );

endmodule

`default_nettype wire

//--- tb_cl_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cl_mem (
   input  logic                clk_out,
   input  logic                sync_rst_n,
   input  logic                awvalid_i,
   output logic                awready_o,
   input  sh_axi_pkg::axi_ax_t aw_i,
   input  logic                wvalid_i,
   output logic                wready_o,
   input  sh_axi_pkg::axi_w_t  w_i,
   output logic                bvalid_o,
   input  logic                bready_i,
   output sh_axi_pkg::axi_b_t  b_o,
   input  logic                arvalid_i,
   output logic                arready_o,
   input  sh_axi_pkg::axi_ax_t ar_i,
   output logic                rvalid_o,
   input  logic                rready_i,
   output sh_axi_pkg::axi_r_t  r_o
);

   sh_axi_pkg::axi_data_t mem [512];
   sh_axi_pkg::axi_ax_t   ax_q [$];
   logic                  is_wr_q [$];
   sh_axi_pkg::axi_w_t    w_q [$];
   int                    seed;

   initial begin
      seed = 32'h180c_d747;
      for (int i = 0; i < 512; i++) begin
         mem[i] = {16'hc0de, 7'h0, 9'(i), 16'hbeef, 7'h0, 9'(i)};
      end
      awready_o = 1'b0;
      wready_o  = 1'b0;
      arready_o = 1'b0;
      bvalid_o  = 1'b0;
      rvalid_o  = 1'b0;
      b_o       = '0;
      r_o       = '0;
   end

   always begin
      logic                b_done;
      logic                r_done;
      logic                is_wr;
      logic [8:0]          idx;
      sh_axi_pkg::axi_ax_t ax;
      sh_axi_pkg::axi_w_t  w;
      @(posedge clk_out);
      b_done = bvalid_o && bready_i;
      r_done = rvalid_o && rready_i;
      // queued in order of address acceptance
      if (sync_rst_n && awvalid_i && awready_o) begin
         ax_q.push_back(aw_i);
         is_wr_q.push_back(1'b1);
      end
      if (sync_rst_n && arvalid_i && arready_o) begin
         ax_q.push_back(ar_i);
         is_wr_q.push_back(1'b0);
      end
      if (sync_rst_n && wvalid_i && wready_o) begin
         w_q.push_back(w_i);
      end
      #2;
      if (b_done) bvalid_o = 1'b0;
      if (r_done) rvalid_o = 1'b0;
      // one response at a time keeps them in request order
      if (!bvalid_o && !rvalid_o && ax_q.size() != 0 && (!is_wr_q[0] || w_q.size() != 0)) begin
         ax    = ax_q.pop_front();
         is_wr = is_wr_q.pop_front();
         idx   = ax.addr[11:3];
         if (is_wr) begin
            w        = w_q.pop_front();
            b_o.id   = ax.id;
            b_o.resp = ax.addr[12] ? sh_axi_pkg::RESP_SLVERR : sh_axi_pkg::RESP_OKAY;
            for (int k = 0; k < 8; k++) begin
               if (!ax.addr[12] && w.strb[k]) mem[idx][8*k +: 8] = w.data[8*k +: 8];
            end
            bvalid_o = 1'b1;
         end else begin
            r_o.id   = ax.id;
            r_o.last = 1'b1;
            r_o.resp = ax.addr[12] ? sh_axi_pkg::RESP_SLVERR : sh_axi_pkg::RESP_OKAY;
            r_o.data = ax.addr[12] ? '0 : mem[idx];
            rvalid_o = 1'b1;
         end
      end
      // random stalls, roughly one cycle in four
      awready_o = sync_rst_n && (($random(seed) & 3) != 0);
      wready_o  = sync_rst_n && (($random(seed) & 3) != 0);
      arready_o = sync_rst_n && (($random(seed) & 3) != 0);
   end

endmodule

`default_nettype wire

//--- tb_sh_pcis_host.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sh_pcis_host;

   localparam int MAX_CYCLES = 20000;

   logic                   clk_out;
   logic                   sync_rst_n;
   logic                   req_valid_i;
   logic                   req_ready_o;
   sh_host_pkg::host_req_t req_i;
   logic                   cpl_valid_o;
   logic                   cpl_ready_i;
   sh_host_pkg::host_cpl_t cpl_o;
   logic                   awvalid_o;
   logic                   awready_i;
   sh_axi_pkg::axi_ax_t    aw_o;
   logic                   wvalid_o;
   logic                   wready_i;
   sh_axi_pkg::axi_w_t     w_o;
   logic                   bvalid_i;
   logic                   bready_o;
   sh_axi_pkg::axi_b_t     b_i;
   logic                   arvalid_o;
   logic                   arready_i;
   sh_axi_pkg::axi_ax_t    ar_o;
   logic                   rvalid_i;
   logic                   rready_o;
   sh_axi_pkg::axi_r_t     r_i;

   sh_axi_pkg::axi_data_t  shadow [512];
   sh_host_pkg::host_cpl_t exp_q [$];
   string                  test_name = "reset";
   int                     seed;
   int                     cycle_cnt = 0;
   int                     check_cnt = 0;
   int                     err_cnt = 0;
   int                     test_err_base = 0;
   int                     tests_run = 0;
   int                     tests_bad = 0;

   sh_pcis_host sh_pcis_host_i (.*);

   tb_cl_mem cl_mem (
      .clk_out    (clk_out),
      .sync_rst_n (sync_rst_n),
      .awvalid_i  (awvalid_o),
      .awready_o  (awready_i),
      .aw_i       (aw_o),
      .wvalid_i   (wvalid_o),
      .wready_o   (wready_i),
      .w_i        (w_o),
      .bvalid_o   (bvalid_i),
      .bready_i   (bready_o),
      .b_o        (b_i),
      .arvalid_i  (arvalid_o),
      .arready_o  (arready_i),
      .ar_i       (ar_o),
      .rvalid_o   (rvalid_i),
      .rready_i   (rready_o),
      .r_o        (r_i)
   );

   initial begin
      clk_out = 1'b0;
      forever #20 clk_out = ~clk_out;
   end

   // ------------------------------
   // reference and compare
   // ------------------------------
   function automatic sh_host_pkg::host_cpl_t expect_cpl(input sh_host_pkg::host_req_t rq);
      sh_host_pkg::host_cpl_t c;
      logic [8:0]             idx;
      idx     = rq.addr[11:3];
      c.kind  = rq.kind;
      c.id    = rq.id;
      c.rdata = '0;
      c.resp  = rq.addr[12] ? sh_axi_pkg::RESP_SLVERR : sh_axi_pkg::RESP_OKAY;
      if (!rq.addr[12] && rq.kind == sh_host_pkg::REQ_WRITE) begin
         if (rq.addr[2]) shadow[idx][63:32] = rq.wdata;
         else shadow[idx][31:0] = rq.wdata;
      end else if (!rq.addr[12]) begin
         c.rdata = shadow[idx];
      end
      return c;
   endfunction

   always @(posedge clk_out) begin
      sh_host_pkg::host_cpl_t exp;
      if (sync_rst_n && cpl_valid_o && cpl_ready_i) begin
         if (exp_q.size() == 0) begin
            err_cnt++;
            $display("completion with id %0d arrived with no request outstanding", cpl_o.id);
         end else begin
            exp = exp_q.pop_front();
            check_cnt++;
            if (cpl_o != exp) begin
               err_cnt++;
               $display("FAILED %s expected %h actual %h", test_name, exp, cpl_o);
            end
         end
      end
   end

   always @(posedge clk_out) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout after %0d cycles in test %s with %0d completions missing",
                  cycle_cnt, test_name, exp_q.size());
         $display("Result: FAILED");
         $finish;
      end
   end

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   task automatic send_req(input sh_host_pkg::req_kind_t kind, input sh_axi_pkg::axi_addr_t addr,
                           input sh_host_pkg::word_t wdata, input sh_axi_pkg::axi_id_t id);
      req_i.kind  = kind;
      req_i.addr  = addr;
      req_i.wdata = wdata;
      req_i.id    = id;
      req_valid_i = 1'b1;
      @(posedge clk_out);
      while (!req_ready_o) @(posedge clk_out);
      #2;
      exp_q.push_back(expect_cpl(req_i));
      req_valid_i = 1'b0;
   endtask

   task automatic start_test(input string name);
      test_name     = name;
      test_err_base = err_cnt;
      tests_run++;
   endtask

   task automatic end_test();
      while (exp_q.size() != 0) @(posedge clk_out);
      #2;
      if (err_cnt == test_err_base) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_bad++;
         $display("test %s: %0d errors", test_name, err_cnt - test_err_base);
      end
   endtask

   initial begin
      sh_host_pkg::req_kind_t kind;
      sh_axi_pkg::axi_addr_t  addr;
      sh_host_pkg::word_t     wdata;
      sh_axi_pkg::axi_id_t    id;
      logic                   stall_seen;
      seed = 32'h180c_d747;
      for (int i = 0; i < 512; i++) begin
         shadow[i] = {16'hc0de, 7'h0, 9'(i), 16'hbeef, 7'h0, 9'(i)};
      end
      sync_rst_n  = 1'b0;
      req_valid_i = 1'b0;
      req_i       = '0;
      cpl_ready_i = 1'b1;
      repeat (5) @(posedge clk_out);
      #2;
      sync_rst_n = 1'b1;

      start_test("reset");
      check_cnt++;
      if (awvalid_o || wvalid_o || arvalid_o || cpl_valid_o || !req_ready_o) begin
         err_cnt++;
         $display("FAILED reset expected aw w ar cpl 0000 ready 1 actual %b%b%b%b ready %b",
                  awvalid_o, wvalid_o, arvalid_o, cpl_valid_o, req_ready_o);
      end
      end_test();

      start_test("write_read");
      send_req(sh_host_pkg::REQ_WRITE, 32'h0000_0104, 32'hdead_beef, 6'd5);
      send_req(sh_host_pkg::REQ_READ, 32'h0000_0104, '0, 6'd6);
      end_test();

      start_test("lane_isolation");
      send_req(sh_host_pkg::REQ_WRITE, 32'h0000_0200, 32'h1111_2222, 6'd1);
      send_req(sh_host_pkg::REQ_WRITE, 32'h0000_0204, 32'h3333_4444, 6'd2);
      send_req(sh_host_pkg::REQ_READ, 32'h0000_0200, '0, 6'd3);
      end_test();

      start_test("slave_error");
      send_req(sh_host_pkg::REQ_WRITE, 32'h0000_1308, 32'h1234_5678, 6'd7);
      send_req(sh_host_pkg::REQ_READ, 32'h0000_1308, '0, 6'd8);
      // alias below bit 12 must be untouched
      send_req(sh_host_pkg::REQ_READ, 32'h0000_0308, '0, 6'd9);
      end_test();

      start_test("mixed_ids");
      for (int i = 0; i < 8; i++) begin
         kind = i[0] ? sh_host_pkg::REQ_READ : sh_host_pkg::REQ_WRITE;
         send_req(kind, 32'h0000_0500 + 32'(4 * (i / 2)), 32'(i * 32'h0101_0101), 6'(i * 9 + 1));
      end
      end_test();

      start_test("backpressure");
      cpl_ready_i = 1'b0;
      stall_seen  = 1'b0;
      fork
         begin
            for (int i = 0; i < 30; i++) begin
               send_req(sh_host_pkg::REQ_READ, 32'h0000_0400 + 32'(8 * i), '0, 6'(i));
            end
         end
         begin
            for (int n = 0; n < 2000 && !stall_seen; n++) begin
               @(posedge clk_out);
               stall_seen = !req_ready_o;
            end
            #2;
            check_cnt++;
            if (!stall_seen) begin
               err_cnt++;
               $display("req_ready_o never dropped while completions were held back");
            end
         end
      join
      // more reads than the completion queue holds, so the bus stalls first
      cpl_ready_i = 1'b1;
      end_test();

      start_test("random_mix");
      for (int i = 0; i < 200; i++) begin
         addr       = '0;
         addr[7:2]  = 6'($random(seed));
         addr[12]   = (($random(seed) & 15) == 0);
         kind       = ($random(seed) & 1) ? sh_host_pkg::REQ_READ : sh_host_pkg::REQ_WRITE;
         wdata      = $random(seed);
         id         = 6'($random(seed));
         send_req(kind, addr, wdata, id);
      end
      end_test();

      $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
               tests_run, tests_bad, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
